/* verilog.f */
+incdir+hdl
hdl/epd_pkg.sv
hdl/pixel_state_ram.sv
hdl/waveform_lut.sv
hdl/pixel_update.sv
hdl/epd_pixel_engine.sv
testbench/tb_epd_pixel_engine.sv

/* Makefile */
TOP = tb_epd_pixel_engine
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Ihdl hdl/epd_pkg.sv hdl/pixel_state_ram.sv \
		hdl/waveform_lut.sv hdl/pixel_update.sv hdl/epd_pixel_engine.sv \
		--top-module epd_pixel_engine

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* testbench/epd_trace.txt */
# L src dst frame code | O valid cmd param framecnt lutframe mindrv | E test name
# F repeat(dec) greys addr0..15 codes addr0..15 (0 none, 1 black, 2 white)
O 0 00 00 00 0 0
F 1 FFFFFFFFFFFFFFFF 0000000000000000
E reset
# Pixel 5 to black, first frame plus 9 counted frames
F 10 FFFFF0FFFFFFFFFF 0000010000000000
F 1 FFFFF0FFFFFFFFFF 0000000000000000
E fast_mono_drive_length
# Pixel 9 to black, reversed while the cap of 2 runs, then 10-7 frames white
O 0 00 00 00 0 2
F 1 FFFFF0FFF0FFFFFF 0000000001000000
F 2 FFFFF0FFFFFFFFFF 0000000001000000
F 4 FFFFF0FFFFFFFFFF 0000000002000000
F 1 FFFFF0FFFFFFFFFF 0000000000000000
E frame_rate_cap
# Set-mode manual LUT, greys match the panel so nothing drives
O 1 02 00 00 0 0
F 1 FFFFF0FFFFFFFFFF 0000000000000000
L F F 3 1
L F F 2 2
L F F 1 1
# Redraw forces target F, greys are ignored
O 1 01 00 00 3 0
F 1 0123456789ABCDEF 0000000000000000
O 0 00 00 00 3 0
F 1 FFFFFFFFFFFFFFFF 1111111111111111
F 1 FFFFFFFFFFFFFFFF 2222222222222222
F 1 FFFFFFFFFFFFFFFF 1111111111111111
F 1 FFFFFFFFFFFFFFFF 0000000000000000
E setmode_manual_redraw
# Back to fast mono, then clear to black (framecnt 18) and to white (01)
O 1 02 02 00 0 0
F 1 FFFFFFFFFFFFFFFF 0000000000000000
O 1 02 02 18 0 0
F 1 0123456789ABCDEF 1111111111111111
O 1 02 02 01 0 0
F 1 0123456789ABCDEF 2222222222222222
O 0 00 00 00 0 0
F 1 FFFFFFFFFFFFFFFF 2222222222222222
F 1 FFFFFFFFFFFFFFFF 0000000000000000
E force_clear

/* testbench/tb_epd_pixel_engine.sv */
//////////////////////////////////////////////////////////////////////
// Trace-driven testbench for the EPD pixel engine
// Run from the project root, the trace path is relative to it
// Each frame drains fully before the next trace line is applied
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_epd_pixel_engine
    import epd_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       pix_valid;
    pixel_req_s pix;
    op_s        op;
    frame_cnt_t csr_lutframe;
    mindrv_t    csr_mindrv;
    logic       lut_wr;
    lut_index_s lut_wr_index;
    drive_t     lut_wr_data;
    logic       drive_valid;
    drive_t     drive;
    pix_addr_t  drive_addr;
    logic       init_busy;

    // Run bookkeeping
    int checks;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    bit timed_out;

    epd_pixel_engine uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .pix          (pix),
        .op           (op),
        .csr_lutframe (csr_lutframe),
        .csr_mindrv   (csr_mindrv),
        .lut_wr       (lut_wr),
        .lut_wr_index (lut_wr_index),
        .lut_wr_data  (lut_wr_data),
        .drive_valid  (drive_valid),
        .drive        (drive),
        .drive_addr   (drive_addr),
        .init_busy    (init_busy)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // One summary line per test, errors counted since the last one
    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic write_lut(input logic [31:0] src, input logic [31:0] dst,
                             input logic [31:0] frm, input logic [31:0] code);
        @(negedge clk);
        lut_wr             = 1'b1;
        lut_wr_index.src   = src[3:0];
        lut_wr_index.dst   = dst[3:0];
        lut_wr_index.frame = frm[3:0];
        lut_wr_data        = drive_t'(code[1:0]);
        @(negedge clk);
        lut_wr = 1'b0;
    endtask

    // Streams addresses 0..15 and checks outputs as they come back
    task automatic run_frame(input logic [63:0] greys, input logic [63:0] codes);
        int sent;
        int seen;
        int cycles;
        sent   = 0;
        seen   = 0;
        cycles = 0;
        while (seen < 16 && cycles < 40) begin
            @(negedge clk);
            // Each pixel comes back exactly 3 cycles after it was issued
            check_value("drive_valid", 32'(drive_valid), 32'(cycles >= 3 && cycles < 19));
            check_value("init_busy", 32'(init_busy), 0);
            if (drive_valid) begin
                check_value($sformatf("drive[%0d]", seen), 32'(drive),
                            32'(codes[63 - 4*seen -: 4]));
                check_value($sformatf("drive_addr[%0d]", seen), 32'(drive_addr), seen);
                seen++;
            end
            if (sent < 16) begin
                pix_valid = 1'b1;
                pix.addr  = pix_addr_t'(sent);
                pix.grey  = greys[63 - 4*sent -: 4];
                sent++;
            end else begin
                pix_valid = 1'b0;
            end
            cycles++;
        end
        pix_valid = 1'b0;
        if (seen < 16) begin
            $display("timeout: frame returned only %0d of 16 pixels", seen);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // Waits out the state sweep, no output may appear meanwhile
    task automatic wait_init();
        int cycles;
        cycles = 0;
        while (init_busy && cycles < 20) begin
            @(negedge clk);
            check_value("drive_valid", 32'(drive_valid), 0);
            cycles++;
        end
        if (init_busy) begin
            $display("timeout: init_busy still high after 20 cycles");
            errors++;
            timed_out = 1'b1;
        end else begin
            // One sweep write per address
            check_value("init_busy_cycles", cycles, 16);
        end
    endtask

    task automatic handle_line(input string line);
        string       rest;
        int          n;
        int          count;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        logic [63:0] greys;
        logic [63:0] codes;
        rest = line.substr(2, line.len() - 1);
        n    = 0;
        case (line[0])
            "L": begin
                n = $sscanf(rest, "%h %h %h %h", f0, f1, f2, f3);
                if (n == 4)
                    write_lut(f0, f1, f2, f3);
            end
            "O": begin
                n = $sscanf(rest, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
                // Op only changes between frames
                @(negedge clk);
                op.valid     = f0[0];
                op.cmd       = f1[7:0];
                op.param     = f2[7:0];
                op.framecnt  = f3[5:0];
                csr_lutframe = f4[5:0];
                csr_mindrv   = f5[1:0];
                n = (n == 6) ? 1 : 0;
            end
            "F": begin
                n = $sscanf(rest, "%d %h %h", count, greys, codes);
                if (n == 3) begin
                    for (int k = 0; k < count && !timed_out; k++)
                        run_frame(greys, codes);
                end
            end
            "E": begin
                // Name runs to the end of the line
                end_test(line.substr(2, line.len() - 2));
                n = 1;
            end
            default: n = 0;
        endcase
        if (n == 0 || (line[0] == "L" && n != 4) || (line[0] == "F" && n != 3)) begin
            $display("trace line could not be read: %s", line);
            errors++;
        end
    endtask

    initial begin
        string line;
        int    fd;
        int    n;
        rst_n        = 1'b0;
        pix_valid    = 1'b0;
        pix          = '0;
        op           = '0;
        csr_lutframe = '0;
        csr_mindrv   = '0;
        lut_wr       = 1'b0;
        lut_wr_index = '0;
        lut_wr_data  = DRIVE_NONE;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;

        // Reset for 8 cycles, outputs must stay quiet
        repeat (8) begin
            @(negedge clk);
            check_value("drive_valid", 32'(drive_valid), 0);
        end
        rst_n = 1'b1;
        wait_init();

        fd = $fopen("testbench/epd_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/epd_trace.txt");
            errors++;
        end else begin
            n = $fgets(line, fd);
            while (n > 0 && !timed_out) begin
                // Skip comments and blank lines
                if (line.len() > 1 && line[0] != "#")
                    handle_line(line);
                n = $fgets(line, fd);
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !timed_out && tests_run > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* hdl/epd_pixel_engine.sv */
//////////////////////////////////////////////////////////////////////
// Three-stage pixel pipeline, pix_valid to drive_valid in 3 cycles
// No stalls or back-pressure, the host takes every output
// An address must not be reissued within 4 cycles
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "epd_params.svh"

module epd_pixel_engine
    import epd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pix_valid,
    input  pixel_req_s pix,
    input  op_s        op,
    input  frame_cnt_t csr_lutframe,
    input  mindrv_t    csr_mindrv,
    input  logic       lut_wr,
    input  lut_index_s lut_wr_index,
    input  drive_t     lut_wr_data,
    output logic       drive_valid,
    output drive_t     drive,
    output pix_addr_t  drive_addr,
    output logic       init_busy
);

    // Stage 1 and 2 pixel context
    logic        s1_valid;
    pix_addr_t   s1_addr;
    grey_t       s1_grey;
    logic        s2_valid;
    pix_addr_t   s2_addr;
    grey_t       s2_grey;
    state_word_t s2_state;

    state_word_t ram_rd_data;
    lut_index_s  lut_rd_index;
    drive_t      lut_rd_data;
    state_word_t upd_state;
    drive_t      upd_drive;

    // Stage 0 reads state straight from the host address
    pixel_state_ram #(
        .ADDR_W (`EPD_PIX_ADDR_W)
    ) u_state_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr   (pix.addr),
        .wr_en     (s2_valid),
        .wr_addr   (s2_addr),
        .wr_data   (upd_state),
        .rd_data   (ram_rd_data),
        .init_busy (init_busy)
    );

    // Stage 1 builds the table index from the stored manual LUT fields
    assign lut_rd_index.src   = ram_rd_data[13:10];
    assign lut_rd_index.dst   = ram_rd_data[3:0];
    assign lut_rd_index.frame = ram_rd_data[7:4];

    waveform_lut u_lut (
        .clk      (clk),
        .rd_index (lut_rd_index),
        .wr_en    (lut_wr),
        .wr_index (lut_wr_index),
        .wr_data  (lut_wr_data),
        .rd_data  (lut_rd_data)
    );

    // Stage 2 rules
    pixel_update u_update (
        .state_in     (s2_state),
        .vin_raw      (s2_grey),
        .lut_rd       (lut_rd_data),
        .op           (op),
        .csr_lutframe (csr_lutframe),
        .csr_mindrv   (csr_mindrv),
        .state_out    (upd_state),
        .drive        (upd_drive)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            drive_valid <= 1'b0;
        end else begin
            s1_valid    <= pix_valid;
            s2_valid    <= s1_valid;
            drive_valid <= s2_valid;
        end
    end

    // Payload follows the valid bits
    always_ff @(posedge clk) begin
        s1_addr    <= pix.addr;
        s1_grey    <= pix.grey;
        s2_addr    <= s1_addr;
        s2_grey    <= s1_grey;
        s2_state   <= ram_rd_data;
        drive      <= upd_drive;
        drive_addr <= s2_addr;
    end

    a_no_pix_during_init: assert property (
        @(posedge clk) disable iff (!rst_n) pix_valid |-> !init_busy
    );

    // Table frame index is only 4 bits
    a_lut_frame_limit: assert property (
        @(posedge clk) disable iff (!rst_n) csr_lutframe <= `EPD_MAX_LUT_FRAMES
    );

endmodule

/* hdl/pixel_update.sv */
//////////////////////////////////////////////////////////////////////
// Next-state and drive rules for one pixel, purely combinational
// Modes other than manual LUT decode as fast mono
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "epd_params.svh"

module pixel_update
    import epd_pkg::*;
(
    input  state_word_t state_in,
    input  grey_t       vin_raw,
    input  drive_t      lut_rd,
    input  op_s         op,
    input  frame_cnt_t  csr_lutframe,
    input  mindrv_t     csr_mindrv,
    output state_word_t state_out,
    output drive_t      drive
);

    // State word fields
    grey_t      lut_target;
    frame_cnt_t fcnt;
    frame_cnt_t fcnt_dec;
    frame_cnt_t fcnt_2w;
    frame_cnt_t fcnt_2b;
    mindrv_t    mindrv;
    mindrv_t    mindrv_dec;
    logic       prev_white;

    assign lut_target = state_in[3:0];
    assign fcnt       = state_in[9:4];
    assign mindrv     = state_in[3:2];
    assign prev_white = state_in[0];
    assign fcnt_dec   = fcnt - 6'd1;
    assign mindrv_dec = (mindrv != 2'd0) ? mindrv - 2'd1 : 2'd0;

    // Reversal mid-drive only runs as long as was already spent
    assign fcnt_2w = `EPD_FASTM_B2W_FRAMES - fcnt + 6'd1;
    assign fcnt_2b = `EPD_FASTM_W2B_FRAMES - fcnt + 6'd1;

    // Mode decode, source bits overlap the low mode bits in manual LUT
    base_mode_t base_mode;

    always_comb begin
        case (state_in[15:14])
            MODE_HI_MANUAL: base_mode = MODE_MANUAL_LUT;
            default:        base_mode = MODE_FAST_MONO;
        endcase
    end

    // Command decode
    logic redraw_en;
    logic setmode_en;
    logic force_clear;
    logic setmode_apply;

    assign redraw_en     = op.valid && (op.cmd == `EPD_OP_REDRAW);
    assign setmode_en    = op.valid && (op.cmd == `EPD_OP_SETMODE);
    // Set-mode with a nonzero frame count clears the panel first
    assign force_clear   = redraw_en || (setmode_en && (op.framecnt != 6'd0));
    assign setmode_apply = setmode_en && (op.framecnt == 6'd0);

    // Clear colour, fast mono alternates by global frame count
    grey_t clear_colour;
    grey_t vin;
    drive_t drive_to_vin;

    always_comb begin
        if (base_mode == MODE_MANUAL_LUT)
            clear_colour = 4'hF;
        else if ((op.framecnt[4:3] == 2'b11) || op.framecnt[5])
            clear_colour = 4'h0;
        else
            clear_colour = 4'hF;
    end

    assign vin          = force_clear ? clear_colour : vin_raw;
    assign drive_to_vin = vin[3] ? DRIVE_WHITE : DRIVE_BLACK;

    always_comb begin
        state_out = state_in;
        drive     = DRIVE_NONE;
        case (base_mode)
            MODE_MANUAL_LUT: begin
                if (fcnt != 6'd0) begin
                    // Sequence running, source and target frozen
                    drive     = lut_rd;
                    state_out = {state_in[15:10], fcnt_dec, state_in[3:0]};
                end else if (force_clear) begin
                    // Old target becomes the new source
                    state_out = {state_in[15:14], lut_target, csr_lutframe, vin};
                end
            end
            default: begin
                if (fcnt != 6'd0) begin
                    if ((vin[3] != prev_white) && (mindrv == 2'd0)) begin
                        // Reverse, cap has expired
                        drive     = drive_to_vin;
                        state_out = vin[3] ?
                            {state_in[15:10], fcnt_2w, csr_mindrv, 2'b01} :
                            {state_in[15:10], fcnt_2b, csr_mindrv, 2'b00};
                    end else begin
                        // Keep pushing the previous colour
                        drive     = prev_white ? DRIVE_WHITE : DRIVE_BLACK;
                        state_out = {state_in[15:10], fcnt_dec, mindrv_dec,
                                     state_in[1:0]};
                    end
                end else if (vin[3] != prev_white) begin
                    // Idle pixel changed colour, start a full drive
                    drive     = drive_to_vin;
                    state_out = vin[3] ?
                        {state_in[15:10], `EPD_FASTM_B2W_FRAMES, csr_mindrv, 2'b01} :
                        {state_in[15:10], `EPD_FASTM_W2B_FRAMES, csr_mindrv, 2'b00};
                end
            end
        endcase

        // Set-mode overrides the state, drive stays as computed
        if (setmode_apply) begin
            case (op.param)
                `EPD_SETMODE_FAST_MONO:  state_out = STATE_PRESET_FAST_MONO;
                `EPD_SETMODE_MANUAL_LUT: state_out = STATE_PRESET_MANUAL;
                // Unknown codes land in manual LUT
                default:                 state_out = STATE_PRESET_MANUAL;
            endcase
        end
    end

endmodule

/* hdl/waveform_lut.sv */
//////////////////////////////////////////////////////////////////////
// Host-written waveform table, 4096 drive codes
// Contents are undefined until the host writes them
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module waveform_lut
    import epd_pkg::*;
(
    input  logic       clk,
    input  lut_index_s rd_index,
    input  logic       wr_en,
    input  lut_index_s wr_index,
    input  drive_t     wr_data,
    output drive_t     rd_data
);

    // Indexed by source, target and frame packed together
    localparam int DEPTH = 1 << $bits(lut_index_s);

    drive_t table_mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en)
            table_mem[wr_index] <= wr_data;
    end

    // Registered read, a write shows up one cycle later
    always_ff @(posedge clk) begin
        rd_data <= table_mem[rd_index];
    end

endmodule

/* hdl/pixel_state_ram.sv */
//////////////////////////////////////////////////////////////////////
// Per-pixel state memory, one registered read and one write a cycle
// After reset every word is set to fast mono white, one per cycle
// Same-address read and write in one cycle returns the old word
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "epd_params.svh"

module pixel_state_ram
    import epd_pkg::*;
#(
    parameter int ADDR_W = `EPD_PIX_ADDR_W
) (
    input  logic        clk,
    input  logic        rst_n,
    input  pix_addr_t   rd_addr,
    input  logic        wr_en,
    input  pix_addr_t   wr_addr,
    input  state_word_t wr_data,
    output state_word_t rd_data,
    output logic        init_busy
);

    localparam int DEPTH = 1 << ADDR_W;

    state_word_t mem [DEPTH];
    logic [ADDR_W-1:0] init_cnt;

    // Write port, the sweep takes it over while busy
    logic        mem_we;
    pix_addr_t   mem_waddr;
    state_word_t mem_wdata;

    assign mem_we    = init_busy | wr_en;
    assign mem_waddr = init_busy ? init_cnt : wr_addr;
    assign mem_wdata = init_busy ? STATE_PRESET_FAST_MONO : wr_data;

    // Sweep counter, busy drops after the last address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_cnt  <= '0;
            init_busy <= 1'b1;
        end else if (init_busy) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == ADDR_W'(DEPTH - 1))
                init_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_we)
            mem[mem_waddr] <= mem_wdata;
        rd_data <= mem[rd_addr];
    end

    // Pipeline writeback must not collide with the sweep
    a_no_write_during_init: assert property (
        @(posedge clk) disable iff (!rst_n) init_busy |-> !wr_en
    );

endmodule

/* hdl/epd_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Types and state word presets shared by the EPD pixel engine
// Pixel address width follows the params header
//////////////////////////////////////////////////////////////////////
`include "epd_params.svh"

package epd_pkg;

    // Plain vectors with a meaning
    typedef logic [3:0]                   grey_t;
    typedef logic [5:0]                   frame_cnt_t;
    typedef logic [1:0]                   mindrv_t;
    typedef logic [`EPD_PIX_ADDR_W-1:0]   pix_addr_t;
    typedef logic [15:0]                  state_word_t;

    // Drive code sent to the panel per pixel
    typedef enum logic [1:0] {
        DRIVE_NONE  = 2'b00,
        DRIVE_BLACK = 2'b01,
        DRIVE_WHITE = 2'b10
    } drive_t;

    // Base mode decoded from the top state bits
    typedef enum logic [1:0] {
        MODE_MANUAL_LUT = 2'b00,
        MODE_FAST_MONO  = 2'b01
    } base_mode_t;

    // Host operation, held through a frame
    typedef struct packed {
        logic       valid;
        logic [7:0] cmd;
        logic [7:0] param;
        frame_cnt_t framecnt;
    } op_s;

    // Waveform table address
    typedef struct packed {
        grey_t src;
        grey_t dst;
        grey_t frame;
    } lut_index_s;

    // One pixel from the host stream
    typedef struct packed {
        pix_addr_t addr;
        grey_t     grey;
    } pixel_req_s;

    // Manual LUT only owns bits 15-14 of the mode field
    localparam logic [1:0] MODE_HI_MANUAL      = 2'b00;
    localparam logic [3:0] MODE_CODE_FAST_MONO = 4'b1000;

    // Preset words written by set-mode and by the reset sweep
    localparam state_word_t STATE_PRESET_MANUAL =
        {MODE_HI_MANUAL, 4'd0, 6'd0, 4'hF};
    localparam state_word_t STATE_PRESET_FAST_MONO =
        {MODE_CODE_FAST_MONO, 2'b00, 6'd0, 2'b00, 1'b0, 1'b1};

endpackage

/* hdl/epd_params.svh */
//////////////////////////////////////////////////////////////////////
// Build-time constants for the EPD pixel engine
// Frame count macros are sized to the 6-bit state counter
// Manual LUT length must stay within 4 bits of table frame index
//////////////////////////////////////////////////////////////////////
`ifndef EPD_PARAMS_SVH
`define EPD_PARAMS_SVH

// Pixel address width, the state memory holds 2^W words
`define EPD_PIX_ADDR_W 4

// Fast mono drive length in frames
`define EPD_FASTM_B2W_FRAMES 6'd9
`define EPD_FASTM_W2B_FRAMES 6'd9

// Longest manual LUT sequence, bounded by the table frame index
`define EPD_MAX_LUT_FRAMES 6'd15

// Host command codes carried in op.cmd
`define EPD_OP_REDRAW  8'h01
`define EPD_OP_SETMODE 8'h02

// Set-mode parameter codes carried in op.param
`define EPD_SETMODE_MANUAL_LUT 8'h00
`define EPD_SETMODE_FAST_MONO  8'h02

`endif
